// ==== hw/cache_pkg.sv ====
package cache_pkg;

    //////////////////////////////
    // Geometry
    //////////////////////////////
    localparam int ADDR_W     = 16;
    localparam int DATA_W     = 16;
    localparam int NUM_PORTS  = 2;
    localparam int LINE_WORDS = 8;
    localparam int NUM_LINES  = 16;
    localparam int PORT_W     = 1;

    // Derived field widths
    localparam int SEL_W   = $clog2(LINE_WORDS);
    localparam int INDEX_W = $clog2(NUM_LINES);
    localparam int OFFS_W  = SEL_W + 1;
    localparam int TAG_W   = ADDR_W - INDEX_W - OFFS_W;

    //////////////////////////////
    // Address fields
    //////////////////////////////
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  word_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [SEL_W-1:0]   word_sel_t;
    typedef logic [PORT_W-1:0]  port_t;

    // Line fill sequencing
    typedef enum logic [1:0] {
        IDLE,
        FILL,
        COMMIT
    } fill_state_t;

    function automatic tag_t addr_tag(addr_t a);
        return a[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic index_t addr_index(addr_t a);
        return a[OFFS_W +: INDEX_W];
    endfunction

    // Bit 0 is the byte within a word and is ignored
    function automatic word_sel_t addr_sel(addr_t a);
        return a[1 +: SEL_W];
    endfunction

    function automatic addr_t line_base(addr_t a);
        return {a[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
    endfunction

endpackage

// ==== hw/l1_cache.sv ====
module l1_cache (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cpu_req,
    input  cache_pkg::addr_t     cpu_addr,
    input  logic                 fill_we,
    input  cache_pkg::word_sel_t fill_sel,
    input  cache_pkg::word_t     fill_data,
    input  logic                 fill_done,
    output logic                 cpu_ready,
    output cache_pkg::word_t     cpu_rdata,
    output logic                 miss,
    output cache_pkg::addr_t     miss_addr
);

    import cache_pkg::*;

    typedef enum logic [1:0] {
        C_IDLE,
        C_RESP,
        C_MISS
    } cache_state_t;

    cache_state_t state_q;

    //////////////////////////////
    // Storage
    //////////////////////////////

    // Tag store, one entry per line
    logic [NUM_LINES-1:0] valid_q;
    tag_t                 tag_arr [NUM_LINES];

    // Word store, addressed by {index, word select}
    word_t                data_arr [NUM_LINES * LINE_WORDS];

    logic      ready_q;
    logic      miss_q;
    addr_t     miss_addr_q;
    word_t     rdata_q;

    index_t    req_index;
    tag_t      req_tag;
    word_sel_t req_sel;
    logic      req_hit;
    logic      req_take;
    index_t    fill_index;
    word_sel_t miss_sel;

    //////////////////////////////
    // Lookup
    //////////////////////////////
    assign req_index = addr_index(cpu_addr);
    assign req_tag   = addr_tag(cpu_addr);
    assign req_sel   = addr_sel(cpu_addr);
    assign req_hit   = valid_q[req_index] && (tag_arr[req_index] == req_tag);

    // New request only accepted from idle
    assign req_take  = (state_q == C_IDLE) && cpu_req;

    // Fill always targets the held miss line
    assign fill_index = addr_index(miss_addr_q);
    assign miss_sel   = addr_sel(miss_addr_q);

    //////////////////////////////
    // Control
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= C_IDLE;
            ready_q <= 1'b0;
            miss_q  <= 1'b0;
            valid_q <= '0;
        end else begin
            case (state_q)
                C_IDLE: begin
                    if (cpu_req) begin
                        if (req_hit) begin
                            ready_q <= 1'b1;
                            state_q <= C_RESP;
                        end else begin
                            miss_q  <= 1'b1;
                            state_q <= C_MISS;
                        end
                    end
                end
                // One cycle of ready, request still held here
                C_RESP: begin
                    ready_q <= 1'b0;
                    state_q <= C_IDLE;
                end
                C_MISS: begin
                    if (fill_done) begin
                        miss_q              <= 1'b0;
                        valid_q[fill_index] <= 1'b1;
                        ready_q             <= 1'b1;
                        state_q             <= C_RESP;
                    end
                end
                default: state_q <= C_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // Arrays and read data
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (req_take) begin
            miss_addr_q <= cpu_addr;
            rdata_q     <= data_arr[{req_index, req_sel}];
        end
        // Last word landed the cycle before, so the line is complete
        if ((state_q == C_MISS) && fill_done) begin
            rdata_q <= data_arr[{fill_index, miss_sel}];
        end
        if (fill_we) begin
            data_arr[{fill_index, fill_sel}] <= fill_data;
        end
        if (fill_done) begin
            tag_arr[fill_index] <= addr_tag(miss_addr_q);
        end
    end

    assign cpu_ready = ready_q;
    assign cpu_rdata = rdata_q;
    assign miss      = miss_q;
    assign miss_addr = miss_addr_q;

    // Ready only answers a request the processor still holds
    a_ready_has_req: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_ready |-> cpu_req);

    // Commit only ever lands on a miss still held
    a_miss_held: assert property (@(posedge clk) disable iff (!rst_n)
        fill_done |-> miss);

endmodule

// ==== hw/line_fill_ctrl.sv ====
module line_fill_ctrl (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic [cache_pkg::NUM_PORTS-1:0]               miss,
    input  cache_pkg::addr_t [cache_pkg::NUM_PORTS-1:0]   miss_addr,
    input  logic                                          wb_ack,
    input  cache_pkg::word_t                              wb_dat,
    output logic [cache_pkg::NUM_PORTS-1:0]               fill_we,
    output cache_pkg::word_sel_t                          fill_sel,
    output cache_pkg::word_t                              fill_data,
    output logic [cache_pkg::NUM_PORTS-1:0]               fill_done,
    output logic                                          wb_cyc,
    output logic                                          wb_stb,
    output cache_pkg::addr_t                              wb_adr
);

    import cache_pkg::*;

    fill_state_t state_q;
    port_t       port_q;
    addr_t       base_q;
    word_sel_t   beat_q;
    logic        cyc_q;
    logic        stb_q;

    logic [NUM_PORTS-1:0] req_mask;
    port_t                next_port;
    logic                 start;
    logic                 beat_ack;
    logic                 last_ack;

    //////////////////////////////
    // Arbitration
    //////////////////////////////

    // Port being committed is excluded so the other one can chain
    always_comb begin
        req_mask = miss;
        if (state_q == COMMIT) begin
            req_mask[port_q] = 1'b0;
        end
    end

    // Fixed priority, lowest port wins
    always_comb begin
        next_port = '0;
        for (int p = NUM_PORTS - 1; p >= 0; p--) begin
            if (req_mask[p]) begin
                next_port = port_t'(p);
            end
        end
    end

    assign start    = (|req_mask) && ((state_q == IDLE) || (state_q == COMMIT));
    assign beat_ack = stb_q && wb_ack;
    assign last_ack = beat_ack && (beat_q == word_sel_t'(LINE_WORDS - 1));

    //////////////////////////////
    // Sequencer
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            port_q  <= '0;
            beat_q  <= '0;
            cyc_q   <= 1'b0;
            stb_q   <= 1'b0;
        end else begin
            case (state_q)
                IDLE, COMMIT: begin
                    if (start) begin
                        state_q <= FILL;
                        port_q  <= next_port;
                        beat_q  <= '0;
                        cyc_q   <= 1'b1;
                        stb_q   <= 1'b1;
                    end else begin
                        state_q <= IDLE;
                    end
                end
                FILL: begin
                    if (beat_ack) begin
                        beat_q <= beat_q + 1'b1;
                    end
                    // Bus released on the eighth ack
                    if (last_ack) begin
                        state_q <= COMMIT;
                        cyc_q   <= 1'b0;
                        stb_q   <= 1'b0;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Line base of the chosen miss
    always_ff @(posedge clk) begin
        if (start) begin
            base_q <= line_base(miss_addr[next_port]);
        end
    end

    //////////////////////////////
    // Bus and cache side
    //////////////////////////////
    assign wb_cyc = cyc_q;
    assign wb_stb = stb_q;

    // Two bytes per beat from the line base
    assign wb_adr = base_q + addr_t'({beat_q, 1'b0});

    assign fill_sel  = beat_q;
    assign fill_data = wb_dat;

    // Steer write and commit strobes to the served cache only
    always_comb begin
        fill_we   = '0;
        fill_done = '0;
        if (beat_ack) begin
            fill_we[port_q] = 1'b1;
        end
        if (state_q == COMMIT) begin
            fill_done[port_q] = 1'b1;
        end
    end

    // Cycle, strobe and address held until the slave acks
    a_beat_held: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> (wb_cyc && wb_stb && $stable(wb_adr)));

    // One waiting cache written per beat
    a_one_fill_we: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(fill_we) && ((fill_we & ~miss) == '0));

    // Bus only busy while the served port still misses
    a_no_cyc_idle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_cyc |-> ((state_q != IDLE) && miss[port_q]));

endmodule

// ==== hw/cache_subsys.sv ====
module cache_subsys (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic [cache_pkg::NUM_PORTS-1:0]               cpu_req,
    input  cache_pkg::addr_t [cache_pkg::NUM_PORTS-1:0]   cpu_addr,
    input  logic                                          wb_ack,
    input  cache_pkg::word_t                              wb_dat,
    output logic [cache_pkg::NUM_PORTS-1:0]               cpu_ready,
    output cache_pkg::word_t [cache_pkg::NUM_PORTS-1:0]   cpu_rdata,
    output logic                                          wb_cyc,
    output logic                                          wb_stb,
    output cache_pkg::addr_t                              wb_adr
);

    import cache_pkg::*;

    // Miss hand-off from the caches
    logic [NUM_PORTS-1:0]  miss;
    addr_t [NUM_PORTS-1:0] miss_addr;

    // Fill path back into the caches
    logic [NUM_PORTS-1:0]  fill_we;
    logic [NUM_PORTS-1:0]  fill_done;
    word_sel_t             fill_sel;
    word_t                 fill_data;

    //////////////////////////////
    // Port caches, 0 = instr, 1 = data
    //////////////////////////////
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_cache
        l1_cache u_cache (
            .clk       (clk),
            .rst_n     (rst_n),
            .cpu_req   (cpu_req[p]),
            .cpu_addr  (cpu_addr[p]),
            .fill_we   (fill_we[p]),
            .fill_sel  (fill_sel),
            .fill_data (fill_data),
            .fill_done (fill_done[p]),
            .cpu_ready (cpu_ready[p]),
            .cpu_rdata (cpu_rdata[p]),
            .miss      (miss[p]),
            .miss_addr (miss_addr[p])
        );
    end

    //////////////////////////////
    // Shared line fill master
    //////////////////////////////
    line_fill_ctrl u_fill (
        .clk       (clk),
        .rst_n     (rst_n),
        .miss      (miss),
        .miss_addr (miss_addr),
        .wb_ack    (wb_ack),
        .wb_dat    (wb_dat),
        .fill_we   (fill_we),
        .fill_sel  (fill_sel),
        .fill_data (fill_data),
        .fill_done (fill_done),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_adr    (wb_adr)
    );

endmodule

// ==== dv/wb_mem_model.sv ====
module wb_mem_model (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cyc,
    input  logic             stb,
    input  cache_pkg::addr_t adr,
    output logic             ack,
    output cache_pkg::word_t dat
);

    import cache_pkg::*;

    integer seed;
    int     wait_cnt;

    initial seed = 32'h6897;

    //////////////////////////////
    // Read slave
    //////////////////////////////

    // Ack is held one cycle, then a fresh delay of 0 to 3 cycles is drawn
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack      <= 1'b0;
            dat      <= '0;
            wait_cnt <= 0;
        end else if (ack) begin
            ack      <= 1'b0;
            wait_cnt <= $unsigned($random(seed)) % 4;
        end else if (cyc && stb) begin
            if (wait_cnt == 0) begin
                ack <= 1'b1;
                // Content is the word address folded with a constant
                dat <= {adr[15:1], 1'b0} ^ 16'h5AC3;
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

endmodule

// ==== dv/tb_cache_subsys.sv ====
module tb_cache_subsys;

    import cache_pkg::*;

    localparam int RAND_READS = 150;
    localparam int WAIT_LIMIT = 200;

    logic                  clk;
    logic                  rst_n;
    logic [NUM_PORTS-1:0]  cpu_req;
    addr_t [NUM_PORTS-1:0] cpu_addr;
    logic [NUM_PORTS-1:0]  cpu_ready;
    word_t [NUM_PORTS-1:0] cpu_rdata;
    logic                  wb_cyc;
    logic                  wb_stb;
    addr_t                 wb_adr;
    logic                  wb_ack;
    word_t                 wb_dat;

    integer seed;
    int     err_cnt;
    int     chk_cnt;
    int     fail_tests;
    int     err_mark;

    // Reference tags per port cache, and every completed bus beat
    logic  model_valid [NUM_PORTS][NUM_LINES];
    tag_t  model_tag [NUM_PORTS][NUM_LINES];
    addr_t beats [$];
    addr_t rand_addr [NUM_PORTS][RAND_READS];
    int    rand_gap [NUM_PORTS][RAND_READS];

    cache_subsys u_dut (
        .clk(clk), .rst_n(rst_n), .cpu_req(cpu_req), .cpu_addr(cpu_addr),
        .wb_ack(wb_ack), .wb_dat(wb_dat), .cpu_ready(cpu_ready), .cpu_rdata(cpu_rdata),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr)
    );

    wb_mem_model u_mem (
        .clk(clk), .rst_n(rst_n), .cyc(wb_cyc), .stb(wb_stb), .adr(wb_adr),
        .ack(wb_ack), .dat(wb_dat)
    );

    always #4 clk = ~clk;

    // Ack lasts one cycle, so each beat is logged once
    always @(negedge clk) begin
        if (wb_cyc && wb_stb && wb_ack) begin
            beats.push_back(wb_adr);
        end
    end

    function automatic word_t mem_word(addr_t a);
        return {a[15:1], 1'b0} ^ 16'h5AC3;
    endfunction

    //////////////////////////////
    // Compare and report
    //////////////////////////////
    task automatic check_word(input string name, input word_t got, input word_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR t=%0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $finish;
    endtask

    task automatic report_test(input int id, input string name);
        if (err_cnt != err_mark) fail_tests++;
        $display("test %0d %s: %s", id, name, (err_cnt == err_mark) ? "ok" : "mismatch");
        err_mark = err_cnt;
    endtask

    //////////////////////////////
    // Processor side
    //////////////////////////////
    task automatic read_access(input int p, input addr_t a, output word_t data, output int cycles);
        cpu_addr[p] = a;
        cpu_req[p]  = 1'b1;
        cycles      = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) abort_run($sformatf("no cpu_ready on port %0d", p));
        end while (!cpu_ready[p]);
        data = cpu_rdata[p];
        // Request stays up through the ready cycle
        @(negedge clk);
        cpu_req[p] = 1'b0;
    endtask

    task automatic checked_read(input int p, input addr_t a, output int cycles, output logic hit);
        word_t data;
        int    first;
        logic  line_beat;
        first     = beats.size();
        hit       = model_valid[p][a[7:4]] && (model_tag[p][a[7:4]] == a[15:8]);
        read_access(p, a, data, cycles);
        check_word($sformatf("cpu_rdata[%0d]", p), data, mem_word(a));
        check_flag($sformatf("one_cycle_hit[%0d]", p), cycles == 1, hit);
        line_beat = 1'b0;
        for (int i = first; i < beats.size(); i++) begin
            if (beats[i][15:4] == a[15:4]) line_beat = 1'b1;
        end
        if (hit) check_flag($sformatf("burst_on_hit_line[%0d]", p), line_beat, 1'b0);
        model_valid[p][a[7:4]] = 1'b1;
        model_tag[p][a[7:4]]   = a[15:8];
    endtask

    task automatic random_stream(input int p);
        int   cycles;
        logic hit;
        for (int i = 0; i < RAND_READS; i++) begin
            repeat (rand_gap[p][i]) @(negedge clk);
            checked_read(p, rand_addr[p][i], cycles, hit);
        end
    endtask

    initial begin
        int   beat0;
        int   lat [NUM_PORTS];
        logic pred [NUM_PORTS];
        clk = 1'b0;
        rst_n = 1'b0;
        cpu_req = '0;
        cpu_addr = '0;
        seed = 32'h6897;
        err_cnt = 0;
        chk_cnt = 0;
        fail_tests = 0;
        err_mark = 0;
        // Each port draws from its own 512-byte window
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int l = 0; l < NUM_LINES; l++) model_valid[p][l] = 1'b0;
            for (int i = 0; i < RAND_READS; i++) begin
                rand_addr[p][i] = addr_t'(32'h2000 + 32'h200 * p
                                          + ($unsigned($random(seed)) % 512));
                rand_gap[p][i]  = $unsigned($random(seed)) % 3;
            end
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        check_flag("cpu_ready[0]", cpu_ready[0], 1'b0);
        check_flag("cpu_ready[1]", cpu_ready[1], 1'b0);
        check_flag("wb_cyc", wb_cyc, 1'b0);
        check_flag("wb_stb", wb_stb, 1'b0);
        for (int p = 0; p < NUM_PORTS; p++) begin
            beat0 = beats.size();
            checked_read(p, (p == 0) ? 16'h0124 : 16'h2346, lat[0], pred[0]);
            check_flag("wb_cyc_on_cold_miss", beats.size() > beat0, 1'b1);
        end
        report_test(1, "reset and cold miss");
        beat0 = beats.size();
        checked_read(0, 16'h012A, lat[0], pred[0]);
        check_flag("hit_in_one_cycle", lat[0] == 1, 1'b1);
        check_flag("bus_idle_on_hit", beats.size() == beat0, 1'b1);
        report_test(2, "hit on filled line");
        beat0 = beats.size();
        checked_read(0, 16'h3A5E, lat[0], pred[0]);
        check_flag("eight_beats", beats.size() - beat0 == 8, 1'b1);
        for (int i = 0; i < 8 && beat0 + i < beats.size(); i++)
            check_addr("wb_adr", beats[beat0 + i], addr_t'(32'h3A50 + 2 * i));
        report_test(3, "burst order");
        beat0 = beats.size();
        fork
            checked_read(0, 16'h4870, lat[0], pred[0]);
            checked_read(1, 16'h9C14, lat[1], pred[1]);
        join
        check_flag("two_bursts", beats.size() - beat0 == 16, 1'b1);
        // Port 0 line first, then port 1 line
        for (int i = 0; i < 16 && beat0 + i < beats.size(); i++)
            check_addr("wb_adr", beats[beat0 + i],
                       addr_t'(((i < 8) ? 32'h4870 : 32'h9C10) + 2 * (i % 8)));
        report_test(4, "simultaneous misses");
        // Same index, other tag, so every read must refill the line
        for (int i = 0; i < 6; i++) begin
            beat0 = beats.size();
            checked_read(1, (i % 2 == 0) ? 16'h0530 : 16'h7530, lat[1], pred[1]);
            check_flag("conflict_miss_burst", beats.size() - beat0 == 8, 1'b1);
        end
        report_test(5, "index conflict");
        fork
            random_stream(0);
            random_stream(1);
        join
        report_test(6, "random reads");
        $display("tests 6 failed %0d checks %0d errors %0d", fail_tests, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
hw/cache_pkg.sv
hw/l1_cache.sv
hw/line_fill_ctrl.sv
hw/cache_subsys.sv
dv/wb_mem_model.sv
dv/tb_cache_subsys.sv

// ==== Makefile ====
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module tb_cache_subsys \
		-Mdir $(OBJ_DIR) -o tb_cache_subsys

run: compile
	./$(OBJ_DIR)/tb_cache_subsys | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
